//--- Makefile
TOP = tb_gat_layer2

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing -f flist.f --top-module $(TOP) -Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bram_sdp.sv
`default_nettype none

// Simple dual-port RAM with one write port and one registered read port
module bram_sdp #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16,
  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  wire              clk,

  // Write port
  input  wire              wr_en,
  input  wire [ADDR_W-1:0] wr_addr,
  input  wire [WIDTH-1:0]  wr_data,

  // Read port with data one cycle after the address
  input  wire [ADDR_W-1:0] rd_addr,
  output logic [WIDTH-1:0] rd_data
);

  // Storage array
  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read
  // A read of the address being written returns the old word
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

//--- flist.f
gat_dims_pkg.sv
gat_ctrl_pkg.sv
bram_sdp.sv
subgraph_handler.sv
gat_layer2_top.sv
tb_gat_layer2.sv

//--- gat_ctrl_pkg.sv
`default_nettype none

package gat_ctrl_pkg;

  // Subgraph handler FSM
  typedef enum logic [2:0] {
    // Waiting for start
    S_IDLE       = 3'd0,
    // Reading the feature vector of the current subgraph
    S_FETCH_FEAT = 3'd1,
    // Two cycles: address out, entry back
    S_FETCH_IDX  = 3'd2,
    // One H word per cycle
    S_SCATTER    = 3'd3,
    // All subgraphs written, gat_ready high
    S_DONE       = 3'd4
  } handler_state_e;

endpackage

`default_nettype wire

//--- gat_dims_pkg.sv
`default_nettype none

package gat_dims_pkg;

  // Layer-1 output word as loaded by the host
  localparam int FEAT_WIDTH = 32;

  // Quantized input word of layer 2
  localparam int DATA_WIDTH = 8;

  // Width of each of the sog and eog flags
  localparam int FLAG_WIDTH = 1;

  // Index entry layout from msb to lsb is {sog, node_idx, eog}
  // Node field width follows from TOTAL_NODES
  localparam int EOG_LSB         = 0;
  localparam int NODE_LSB        = FLAG_WIDTH;
  localparam int ENTRY_FLAG_BITS = 2 * FLAG_WIDTH;

  // One feature word in the feature memory
  typedef logic [FEAT_WIDTH-1:0] feat_word_t;

  // One word of the H data memory
  typedef logic [DATA_WIDTH-1:0] h_word_t;

endpackage

`default_nettype wire

//--- gat_layer2_top.sv
`default_nettype none

// Layer-2 input stage: feature memory, index memory, H memory and the
// subgraph handler that fills H from the other two
module gat_layer2_top #(
  parameter int NUM_FEATURE_OUT = 16,
  parameter int NUM_SUBGRAPHS   = 8,
  parameter int TOTAL_NODES     = 64,
  parameter int NUM_ENTRIES     = 64,

  // Memory sizes
  localparam int FEAT_DEPTH  = NUM_SUBGRAPHS * NUM_FEATURE_OUT,
  localparam int FEAT_ADDR_W = (FEAT_DEPTH > 1) ? $clog2(FEAT_DEPTH) : 1,
  localparam int NODE_W      = (TOTAL_NODES > 1) ? $clog2(TOTAL_NODES) : 1,
  localparam int ENTRY_W     = gat_dims_pkg::ENTRY_FLAG_BITS + NODE_W,
  localparam int IDX_ADDR_W  = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1,
  localparam int H_DEPTH     = TOTAL_NODES * NUM_FEATURE_OUT,
  localparam int H_ADDR_W    = (H_DEPTH > 1) ? $clog2(H_DEPTH) : 1
) (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire                            start,

  // Host load of the feature memory
  input  wire                            feat_wr_en,
  input  wire [FEAT_ADDR_W-1:0]          feat_wr_addr,
  input  wire gat_dims_pkg::feat_word_t  feat_wr_data,

  // Host load of the index memory
  input  wire                            idx_wr_en,
  input  wire [IDX_ADDR_W-1:0]           idx_wr_addr,
  input  wire [ENTRY_W-1:0]              idx_wr_data,

  // Host read of the H memory
  input  wire [H_ADDR_W-1:0]             h_rd_addr,
  output gat_dims_pkg::h_word_t          h_rd_data,

  output logic                           gat_ready
);

  import gat_dims_pkg::*;

  // Handler side of the feature memory
  logic [FEAT_ADDR_W-1:0] feat_rd_addr;
  feat_word_t             feat_rd_data;

  // Handler side of the index memory
  logic [IDX_ADDR_W-1:0]  idx_rd_addr;
  logic [ENTRY_W-1:0]     idx_rd_data;

  // Handler writes into H
  logic                   h_wr_en;
  logic [H_ADDR_W-1:0]    h_wr_addr;
  h_word_t                h_wr_data;

  // One layer-1 vector per subgraph
  bram_sdp #(
    .WIDTH (FEAT_WIDTH),
    .DEPTH (FEAT_DEPTH)
  ) u_feat_mem (
    .clk     (clk),
    .wr_en   (feat_wr_en),
    .wr_addr (feat_wr_addr),
    .wr_data (feat_wr_data),
    .rd_addr (feat_rd_addr),
    .rd_data (feat_rd_data)
  );

  // Subgraph index list
  bram_sdp #(
    .WIDTH (ENTRY_W),
    .DEPTH (NUM_ENTRIES)
  ) u_idx_mem (
    .clk     (clk),
    .wr_en   (idx_wr_en),
    .wr_addr (idx_wr_addr),
    .wr_data (idx_wr_data),
    .rd_addr (idx_rd_addr),
    .rd_data (idx_rd_data)
  );

  // H data, read port goes straight out to the host
  bram_sdp #(
    .WIDTH (DATA_WIDTH),
    .DEPTH (H_DEPTH)
  ) u_h_mem (
    .clk     (clk),
    .wr_en   (h_wr_en),
    .wr_addr (h_wr_addr),
    .wr_data (h_wr_data),
    .rd_addr (h_rd_addr),
    .rd_data (h_rd_data)
  );

  subgraph_handler #(
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT),
    .NUM_SUBGRAPHS   (NUM_SUBGRAPHS),
    .TOTAL_NODES     (TOTAL_NODES),
    .NUM_ENTRIES     (NUM_ENTRIES)
  ) u_handler (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .feat_rd_addr (feat_rd_addr),
    .feat_rd_data (feat_rd_data),
    .idx_rd_addr  (idx_rd_addr),
    .idx_rd_data  (idx_rd_data),
    .h_wr_en      (h_wr_en),
    .h_wr_addr    (h_wr_addr),
    .h_wr_data    (h_wr_data),
    .gat_ready    (gat_ready)
  );

endmodule

`default_nettype wire

//--- subgraph_handler.sv
`default_nettype none

// Walks the subgraph index list and scatters each subgraph's feature
// vector into the H memory, once per listed node
module subgraph_handler #(
  parameter int NUM_FEATURE_OUT = 16,
  parameter int NUM_SUBGRAPHS   = 8,
  parameter int TOTAL_NODES     = 64,
  parameter int NUM_ENTRIES     = 64,

  localparam int NODE_W      = (TOTAL_NODES > 1) ? $clog2(TOTAL_NODES) : 1,
  localparam int ENTRY_W     = gat_dims_pkg::ENTRY_FLAG_BITS + NODE_W,
  localparam int FEAT_DEPTH  = NUM_SUBGRAPHS * NUM_FEATURE_OUT,
  localparam int FEAT_ADDR_W = (FEAT_DEPTH > 1) ? $clog2(FEAT_DEPTH) : 1,
  localparam int IDX_ADDR_W  = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1,
  localparam int H_DEPTH     = TOTAL_NODES * NUM_FEATURE_OUT,
  localparam int H_ADDR_W    = (H_DEPTH > 1) ? $clog2(H_DEPTH) : 1
) (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       start,

  // Feature memory read port
  output logic [FEAT_ADDR_W-1:0]    feat_rd_addr,
  input  wire gat_dims_pkg::feat_word_t feat_rd_data,

  // Index memory read port
  output logic [IDX_ADDR_W-1:0]     idx_rd_addr,
  input  wire [ENTRY_W-1:0]         idx_rd_data,

  // H memory write port
  output logic                      h_wr_en,
  output logic [H_ADDR_W-1:0]       h_wr_addr,
  output gat_dims_pkg::h_word_t     h_wr_data,

  output logic                      gat_ready
);

  import gat_dims_pkg::*;
  import gat_ctrl_pkg::*;

  // Word position inside one feature vector
  localparam int WORD_W = (NUM_FEATURE_OUT > 1) ? $clog2(NUM_FEATURE_OUT) : 1;
  // Word counter also has to reach NUM_FEATURE_OUT for the last capture
  localparam int CNT_W  = $clog2(NUM_FEATURE_OUT + 1);
  localparam int SUB_W  = (NUM_SUBGRAPHS > 1) ? $clog2(NUM_SUBGRAPHS) : 1;

  localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(NUM_FEATURE_OUT - 1);
  localparam logic [CNT_W-1:0] FETCH_END = CNT_W'(NUM_FEATURE_OUT);
  localparam logic [SUB_W-1:0] LAST_SUB  = SUB_W'(NUM_SUBGRAPHS - 1);

  handler_state_e state;

  // Counters
  logic [IDX_ADDR_W-1:0] entry_ptr;
  logic [SUB_W-1:0]      sub_cnt;
  logic [CNT_W-1:0]      word_cnt;
  logic                  idx_phase;

  logic [WORD_W-1:0]     word_idx;
  logic [CNT_W-1:0]      cap_cnt;
  logic [WORD_W-1:0]     cap_idx;

  // Fields of the entry coming back from the index memory
  logic                  entry_sog;
  logic [NODE_W-1:0]     entry_node;
  logic                  entry_eog;

  // Current entry
  logic [NODE_W-1:0]     cur_node;
  logic                  cur_eog;

  // Held feature vector of the current subgraph
  feat_word_t            feat_bank [NUM_FEATURE_OUT];

  logic [FEAT_ADDR_W-1:0] feat_base;
  logic [H_ADDR_W-1:0]    node_base;

  // Entry unpacking
  assign entry_sog  = idx_rd_data[ENTRY_W-1];
  assign entry_node = idx_rd_data[NODE_LSB +: NODE_W];
  assign entry_eog  = idx_rd_data[EOG_LSB];

  assign word_idx = word_cnt[WORD_W-1:0];

  // Read data lags the address by one cycle, so capture one word behind
  assign cap_cnt = word_cnt - CNT_W'(1);
  assign cap_idx = cap_cnt[WORD_W-1:0];

  // Feature vector of subgraph k starts at k * NUM_FEATURE_OUT
  assign feat_base    = FEAT_ADDR_W'(sub_cnt * NUM_FEATURE_OUT);
  assign feat_rd_addr = feat_base + FEAT_ADDR_W'(word_idx);

  assign idx_rd_addr = entry_ptr;

  // Node n owns H words n * NUM_FEATURE_OUT onwards
  assign node_base = H_ADDR_W'(cur_node * NUM_FEATURE_OUT);
  assign h_wr_en   = (state == S_SCATTER);
  assign h_wr_addr = node_base + H_ADDR_W'(word_idx);
  // Low bits only, the quantized format of layer 2
  assign h_wr_data = feat_bank[word_idx][DATA_WIDTH-1:0];

  assign gat_ready = (state == S_DONE);

  // Control FSM
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      entry_ptr <= '0;
      sub_cnt   <= '0;
      word_cnt  <= '0;
      idx_phase <= 1'b0;
      cur_eog   <= 1'b0;
    end else begin
      case (state)
        S_IDLE, S_DONE: begin
          if (start) begin
            state     <= S_FETCH_IDX;
            entry_ptr <= '0;
            sub_cnt   <= '0;
            word_cnt  <= '0;
            idx_phase <= 1'b0;
          end
        end

        S_FETCH_IDX: begin
          if (!idx_phase) begin
            // Address is out, entry arrives next cycle
            idx_phase <= 1'b1;
          end else begin
            idx_phase <= 1'b0;
            cur_eog   <= entry_eog;
            word_cnt  <= '0;
            // First node of a subgraph pulls in a new vector
            if (entry_sog) begin
              state <= S_FETCH_FEAT;
            end else begin
              state <= S_SCATTER;
            end
          end
        end

        S_FETCH_FEAT: begin
          if (word_cnt == FETCH_END) begin
            word_cnt <= '0;
            state    <= S_SCATTER;
          end else begin
            word_cnt <= word_cnt + 1'b1;
          end
        end

        S_SCATTER: begin
          if (word_cnt == LAST_WORD) begin
            word_cnt <= '0;
            if (cur_eog && (sub_cnt == LAST_SUB)) begin
              state <= S_DONE;
            end else begin
              state     <= S_FETCH_IDX;
              entry_ptr <= entry_ptr + 1'b1;
              // Next vector belongs to the following subgraph
              if (cur_eog) begin
                sub_cnt <= sub_cnt + 1'b1;
              end
            end
          end else begin
            word_cnt <= word_cnt + 1'b1;
          end
        end

        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if ((state == S_FETCH_FEAT) && (word_cnt != '0)) begin
      feat_bank[cap_idx] <= feat_rd_data;
    end
    if ((state == S_FETCH_IDX) && idx_phase) begin
      cur_node <= entry_node;
    end
  end

endmodule

`default_nettype wire

//--- tb_gat_layer2.sv
`default_nettype none

module tb_gat_layer2;

  timeunit 1ns;
  timeprecision 100ps;

  import gat_dims_pkg::*;
  import gat_ctrl_pkg::*;

  localparam int NUM_FEATURE_OUT = 4;
  localparam int NUM_SUBGRAPHS   = 6;
  localparam int TOTAL_NODES     = 16;
  localparam int NUM_ENTRIES     = 24;
  localparam int MAX_SUB_SIZE    = 8;

  localparam int NODE_W      = $clog2(TOTAL_NODES);
  localparam int ENTRY_W     = ENTRY_FLAG_BITS + NODE_W;
  localparam int FEAT_DEPTH  = NUM_SUBGRAPHS * NUM_FEATURE_OUT;
  localparam int FEAT_ADDR_W = $clog2(FEAT_DEPTH);
  localparam int IDX_ADDR_W  = $clog2(NUM_ENTRIES);
  localparam int H_DEPTH     = TOTAL_NODES * NUM_FEATURE_OUT;
  localparam int H_ADDR_W    = $clog2(H_DEPTH);

  // Worst case of three runs, every entry with a fetch, plus margin
  localparam int TIMEOUT_CYCLES = 3 * (NUM_ENTRIES * (2 + NUM_FEATURE_OUT) +
                                       NUM_SUBGRAPHS * (NUM_FEATURE_OUT + 1)) + 200;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   start;
  logic                   feat_wr_en;
  logic [FEAT_ADDR_W-1:0] feat_wr_addr;
  feat_word_t             feat_wr_data;
  logic                   idx_wr_en;
  logic [IDX_ADDR_W-1:0]  idx_wr_addr;
  logic [ENTRY_W-1:0]     idx_wr_data;
  logic [H_ADDR_W-1:0]    h_rd_addr;
  h_word_t                h_rd_data;
  logic                   gat_ready;

  // Host-side copy of what was loaded
  feat_word_t             feat_img [FEAT_DEPTH];
  logic [ENTRY_W-1:0]     idx_list [NUM_ENTRIES];
  int                     sizes [NUM_SUBGRAPHS];
  int                     dup_node;
  logic [31:0]            rng_state = 32'd61;

  // Read-back pipeline, expected value follows the address by one cycle
  logic                   rd_req;
  h_word_t                rd_exp;
  logic                   chk_valid = 1'b0;
  h_word_t                chk_exp;

  int                     errors = 0;
  int                     checks = 0;
  int                     tests_run = 0;
  int                     tests_passed = 0;
  logic                   waiting = 1'b0;
  int                     wait_cycles = 0;
  handler_state_e         handler_state;

  assign handler_state = u_gat_layer2_top.u_handler.state;

  gat_layer2_top #(
    .NUM_FEATURE_OUT (NUM_FEATURE_OUT),
    .NUM_SUBGRAPHS   (NUM_SUBGRAPHS),
    .TOTAL_NODES     (TOTAL_NODES),
    .NUM_ENTRIES     (NUM_ENTRIES)
  ) u_gat_layer2_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .feat_wr_en   (feat_wr_en),
    .feat_wr_addr (feat_wr_addr),
    .feat_wr_data (feat_wr_data),
    .idx_wr_en    (idx_wr_en),
    .idx_wr_addr  (idx_wr_addr),
    .idx_wr_data  (idx_wr_data),
    .h_rd_addr    (h_rd_addr),
    .h_rd_data    (h_rd_data),
    .gat_ready    (gat_ready)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [ENTRY_W-1:0] make_entry(input logic sog, input int node,
                                                    input logic eog);
    return {sog, NODE_W'(node), eog};
  endfunction

  // Expected H word, MSB set when some entry writes it; later entries overwrite
  function automatic logic [DATA_WIDTH:0] ref_h_word(input int addr);
    logic [DATA_WIDTH:0] res;
    int                  sub;
    int                  node;
    res = '0;
    sub = 0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (sub < NUM_SUBGRAPHS) begin
        node = int'(idx_list[i][NODE_LSB +: NODE_W]);
        if (node == addr / NUM_FEATURE_OUT) begin
          res = {1'b1, feat_img[sub * NUM_FEATURE_OUT + addr % NUM_FEATURE_OUT][DATA_WIDTH-1:0]};
        end
        if (idx_list[i][EOG_LSB]) begin
          sub++;
        end
      end
    end
    return res;
  endfunction

  task automatic check_h_word(input string name, input h_word_t got, input h_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s got 0x%02h, expected 0x%02h", $time, name, got, exp);
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s got %b, expected %b", $time, name, got, exp);
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic step_clock();
    @(posedge clk);
    #1;
  endtask

  task automatic draw_random(output logic [31:0] v);
    rng_state = xorshift32(rng_state);
    v = rng_state;
  endtask

  task automatic build_random_list();
    logic [31:0] r;
    int          a;
    int          b;
    int          e;
    for (int s = 0; s < NUM_SUBGRAPHS; s++) begin
      sizes[s] = NUM_ENTRIES / NUM_SUBGRAPHS;
    end
    // Move nodes between subgraphs, total stays NUM_ENTRIES
    repeat (40) begin
      draw_random(r);
      a = int'(r % NUM_SUBGRAPHS);
      draw_random(r);
      b = int'(r % NUM_SUBGRAPHS);
      if (a != b && sizes[a] < MAX_SUB_SIZE && sizes[b] > 1) begin
        sizes[a]++;
        sizes[b]--;
      end
    end
    e = 0;
    for (int s = 0; s < NUM_SUBGRAPHS; s++) begin
      for (int k = 0; k < sizes[s]; k++) begin
        draw_random(r);
        idx_list[e] = make_entry(k == 0, int'(r % TOTAL_NODES), k == sizes[s] - 1);
        e++;
      end
    end
    // Last subgraph always revisits the first node of subgraph 0
    dup_node = int'(idx_list[0][NODE_LSB +: NODE_W]);
    e = NUM_ENTRIES - sizes[NUM_SUBGRAPHS-1];
    idx_list[e][NODE_LSB +: NODE_W] = NODE_W'(dup_node);
  endtask

  task automatic build_single_node_list();
    logic [31:0] r;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      draw_random(r);
      if (i < NUM_SUBGRAPHS) begin
        idx_list[i] = make_entry(1'b1, int'(r % TOTAL_NODES), 1'b1);
      end else begin
        idx_list[i] = '0;
      end
    end
  endtask

  task automatic load_index_mem();
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      idx_wr_en   = 1'b1;
      idx_wr_addr = IDX_ADDR_W'(i);
      idx_wr_data = idx_list[i];
      step_clock();
    end
    idx_wr_en = 1'b0;
  endtask

  task automatic load_feature_mem();
    logic [31:0] r;
    for (int i = 0; i < FEAT_DEPTH; i++) begin
      draw_random(r);
      feat_img[i]  = r;
      feat_wr_en   = 1'b1;
      feat_wr_addr = FEAT_ADDR_W'(i);
      feat_wr_data = r;
      step_clock();
    end
    feat_wr_en = 1'b0;
  endtask

  task automatic pulse_start();
    start = 1'b1;
    step_clock();
    start = 1'b0;
  endtask

  task automatic wait_for_ready();
    waiting = 1'b1;
    do begin
      @(negedge clk);
    end while (gat_ready !== 1'b1);
    waiting = 1'b0;
    step_clock();
  endtask

  task automatic issue_read(input int addr, input h_word_t exp);
    h_rd_addr = H_ADDR_W'(addr);
    rd_exp    = exp;
    rd_req    = 1'b1;
    step_clock();
  endtask

  task automatic drain_reads();
    rd_req = 1'b0;
    step_clock();
    step_clock();
  endtask

  task automatic check_h_image();
    logic [DATA_WIDTH:0] r;
    for (int a = 0; a < H_DEPTH; a++) begin
      r = ref_h_word(a);
      if (r[DATA_WIDTH]) begin
        issue_read(a, r[DATA_WIDTH-1:0]);
      end
    end
    drain_reads();
  endtask

  // Node shared by subgraph 0 and the last subgraph holds the last vector
  task automatic check_repeated_node();
    for (int w = 0; w < NUM_FEATURE_OUT; w++) begin
      issue_read(dup_node * NUM_FEATURE_OUT + w,
                 feat_img[(NUM_SUBGRAPHS - 1) * NUM_FEATURE_OUT + w][DATA_WIDTH-1:0]);
    end
    drain_reads();
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      tests_passed++;
      $display("pass: %s", name);
    end else begin
      $display("FAIL: %s, %0d errors", name, errors - errs_before);
    end
  endtask

  always @(posedge clk) begin
    chk_valid <= rd_req;
    chk_exp   <= rd_exp;
  end

  // H data is stable by the falling edge
  always @(negedge clk) begin
    if (chk_valid) begin
      check_h_word("h_rd_data", h_rd_data, chk_exp);
    end
  end

  always @(posedge clk) begin
    if (waiting) begin
      wait_cycles <= wait_cycles + 1;
      if (wait_cycles >= TIMEOUT_CYCLES) begin
        $display("ERROR: timeout waiting for gat_ready, handler in %s", handler_state.name());
        $display("Test failed");
        $finish;
      end
    end
  end

  initial begin
    int errs;
    rst_n        = 1'b0;
    start        = 1'b0;
    feat_wr_en   = 1'b0;
    feat_wr_addr = '0;
    feat_wr_data = '0;
    idx_wr_en    = 1'b0;
    idx_wr_addr  = '0;
    idx_wr_data  = '0;
    h_rd_addr    = '0;
    rd_req       = 1'b0;
    rd_exp       = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    errs = errors;
    repeat (10) begin
      @(negedge clk);
      check_level("gat_ready", gat_ready, 1'b0);
    end
    step_clock();
    report_test("1 gat_ready low after reset", errs);

    errs = errors;
    build_random_list();
    load_index_mem();
    load_feature_mem();
    pulse_start();
    wait_for_ready();
    check_h_image();
    report_test("2 first run H image", errs);

    errs = errors;
    check_repeated_node();
    report_test("3 repeated node keeps later subgraph", errs);

    // New vectors for run 2 while the handler sits in S_DONE
    errs = errors;
    load_feature_mem();
    repeat (20) begin
      @(negedge clk);
      check_level("gat_ready", gat_ready, 1'b1);
    end
    step_clock();
    pulse_start();
    @(negedge clk);
    check_level("gat_ready", gat_ready, 1'b0);
    report_test("4 gat_ready holds then clears on start", errs);

    errs = errors;
    wait_for_ready();
    check_h_image();
    report_test("5 second run with new features", errs);

    errs = errors;
    build_single_node_list();
    load_index_mem();
    load_feature_mem();
    pulse_start();
    wait_for_ready();
    check_h_image();
    report_test("6 one node per subgraph", errs);

    $display("Summary: %0d of %0d tests passed, %0d checks, %0d errors",
             tests_passed, tests_run, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
